//--- fp_mul.f
+incdir+source
+incdir+verif
source/fp_mul_pkg.sv
source/fp_mul_mant.sv
source/fp_mul_exp.sv
source/fp_mul_pack.sv
source/fp_mul.sv
verif/tb_fp_mul.sv

//--- verif/fp_mul_model.svh
`ifndef FP_MUL_MODEL_SVH
`define FP_MUL_MODEL_SVH

// fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// exponent high bit sits above the sign
function automatic logic [32:0] word_of(
  input logic        s,
  input logic [8:0]  e,
  input logic [22:0] f
);
  word_of = {e[8], s, e[7:0], f};
endfunction

// expected {flags, res} of one operation
function automatic logic [36:0] model_mul(
  input logic [32:0] a,
  input logic [32:0] b,
  input logic        copy,
  input logic        nan_sig,
  input logic [2:0]  mode
);
  logic [8:0]  ea;
  logic [8:0]  eb;
  logic        s;
  logic [47:0] p;
  logic [23:0] kept;
  logic        r;
  logic        st;
  logic        up;
  logic [3:0]  fl;
  int          e;
  ea = {a[32], a[30:23]};
  eb = {b[32], b[30:23]};
  s  = a[31] ^ b[31];
  fl = 4'b0000;
  if (copy) begin
    return {fl, a};
  end
  if (ea == `FPM_EXP_NAN || eb == `FPM_EXP_NAN ||
      (ea == `FPM_EXP_INF && eb == 9'd0) || (ea == 9'd0 && eb == `FPM_EXP_INF)) begin
    if (nan_sig) begin
      fl[`FPM_FLAG_INV] = 1'b1;
      return {fl, word_of(1'b1, `FPM_EXP_NAN, `FPM_SNAN_FRAC)};
    end
    return {fl, word_of(1'b1, `FPM_EXP_NAN, `FPM_QNAN_FRAC)};
  end
  if (ea == `FPM_EXP_INF || eb == `FPM_EXP_INF) begin
    return {fl, word_of(s, `FPM_EXP_INF, 23'd0)};
  end
  if (ea == 9'd0 || eb == 9'd0) begin
    return {fl, word_of(s, 9'd0, 23'd0)};
  end
  p = {1'b1, a[22:0]} * {1'b1, b[22:0]};
  e = int'(ea) + int'(eb) - int'(`FPM_BIAS);
  // bring the leading one up to bit 47
  if (p[47]) begin
    e = e + 1;
  end else begin
    p = p << 1;
  end
  r  = p[23];
  st = |p[22:0];
  case (mode)
    3'd1: up = r;
    3'd2: up = r && (st || p[24]);
    3'd3: up = r && !s;
    3'd4: up = r && s;
    3'd5: up = (r || st) && !s;
    3'd6: up = (r || st) && s;
    default: up = 1'b0;
  endcase
  kept = {1'b0, p[46:24]} + {23'd0, up};
  if (kept[23]) begin
    e = e + 1;
  end
  if (e >= int'(`FPM_EXP_INF)) begin
    fl[`FPM_FLAG_OVF] = 1'b1;
    fl[`FPM_FLAG_INX] = 1'b1;
    return {fl, word_of(s, `FPM_EXP_INF, 23'd0)};
  end
  if (e <= 0) begin
    fl[`FPM_FLAG_UNF] = 1'b1;
    fl[`FPM_FLAG_INX] = 1'b1;
    return {fl, word_of(s, 9'd0, 23'd0)};
  end
  fl[`FPM_FLAG_INX] = r || st;
  return {fl, word_of(s, e[8:0], kept[22:0])};
endfunction

`endif

//--- verif/tb_fp_mul.sv
`timescale 1ns/1ps
`default_nettype none

`include "fp_mul_cfg.svh"

module tb_fp_mul import fp_mul_pkg::*; ();

  localparam int RESET_CYCLES = 5;
  localparam int NUM_DIRECTED = 5;
  localparam int NUM_RANDOM   = 2000;
  // every stimulus cycle, the drain, and margin
  localparam int MAX_CYCLES   = RESET_CYCLES + NUM_DIRECTED + NUM_RANDOM + 50;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        en;
  logic        copy_a;
  logic        nan_signal;
  logic [32:0] a;
  logic [32:0] b;
  round_mode_e rmode;
  logic [32:0] res;
  logic [3:0]  flags;
  logic        out_en;

  logic [31:0] lfsr;
  logic [2:0]  en_hist;
  logic [36:0] exp_q[$];
  string       name_q[$];
  int          cycles = 0;
  int          res_errors = 0;
  int          flag_errors = 0;
  int          seq_errors = 0;

  `include "fp_mul_model.svh"

  fp_mul dut0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .en         (en),
    .copy_a     (copy_a),
    .nan_signal (nan_signal),
    .a          (a),
    .b          (b),
    .rmode      (rmode),
    .res        (res),
    .flags      (flags),
    .out_en     (out_en)
  );

  initial begin
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > MAX_CYCLES) begin
      $display("timeout after %0d cycles, results still pending", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic take_bits(input int n, output logic [31:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic rand_operand(output logic [32:0] x);
    logic [31:0] sel;
    logic [31:0] v;
    logic [8:0]  e;
    logic [22:0] f;
    take_bits(4, sel);
    take_bits(9, v);
    case (sel[3:0])
      4'd0: e = 9'h000;
      4'd1: e = `FPM_EXP_INF;
      4'd2: e = `FPM_EXP_NAN;
      4'd3, 4'd4: e = 9'h17c + {6'd0, v[2:0]};
      4'd5, 4'd6: e = 9'h07c + {6'd0, v[2:0]};
      default: e = v[8:0];
    endcase
    take_bits(2, sel);
    take_bits(23, v);
    // fractions just under two or just over one so rounding can carry out
    case (sel[1:0])
      2'd0: f = {20'hfffff, v[2:0]};
      2'd1: f = {20'h00000, v[2:0]};
      default: f = v[22:0];
    endcase
    take_bits(1, v);
    x = word_of(v[0], e, f);
  endtask

  function automatic string op_name(
    input logic [32:0] x,
    input logic [32:0] y,
    input logic        cp,
    input logic [2:0]  mode
  );
    logic [8:0] ex;
    logic [8:0] ey;
    ex = {x[32], x[30:23]};
    ey = {y[32], y[30:23]};
    if (cp) return "copy_a";
    if (ex == `FPM_EXP_NAN || ey == `FPM_EXP_NAN) return "nan operand";
    if (ex == `FPM_EXP_INF || ey == `FPM_EXP_INF) return "inf operand";
    if (ex == 9'd0 || ey == 9'd0) return "zero operand";
    return $sformatf("product rmode %0d", mode);
  endfunction

  task automatic check_outputs();
    logic [36:0] want;
    string       name;
    assert (out_en === en_hist[2]) else begin
      seq_errors++;
      $display("mismatch out_en timing: expected %b actual %b", en_hist[2], out_en);
    end
    if (out_en === 1'b1) begin
      assert (exp_q.size() > 0) else begin
        seq_errors++;
        $display("out_en went high while no result was expected");
      end
      if (exp_q.size() > 0) begin
        want = exp_q.pop_front();
        name = name_q.pop_front();
        assert (res === want[32:0]) else begin
          res_errors++;
          $display("mismatch %s res: expected %h actual %h", name, want[32:0], res);
        end
        assert (flags === want[36:33]) else begin
          flag_errors++;
          $display("mismatch %s flags: expected %b actual %b", name, want[36:33], flags);
        end
      end
    end
  endtask

  // check last edge's outputs, then drive the next inputs
  task automatic run_cycle(
    input logic        op_en,
    input logic [32:0] op_a,
    input logic [32:0] op_b,
    input logic        op_copy,
    input logic        op_nan,
    input logic [2:0]  op_mode
  );
    @(negedge clk);
    check_outputs();
    en         = op_en;
    a          = op_a;
    b          = op_b;
    copy_a     = op_copy;
    nan_signal = op_nan;
    rmode      = round_mode_e'(op_mode);
    if (op_en) begin
      exp_q.push_back(model_mul(op_a, op_b, op_copy, op_nan, op_mode));
      name_q.push_back(op_name(op_a, op_b, op_copy, op_mode));
    end
    en_hist = {en_hist[1:0], op_en};
  endtask

  initial begin
    logic [32:0] op_a;
    logic [32:0] op_b;
    logic [31:0] ctl;
    int          i;
    rst_n      = 1'b0;
    en         = 1'b0;
    copy_a     = 1'b0;
    nan_signal = 1'b0;
    a          = '0;
    b          = '0;
    rmode      = RND_TRUNC;
    lfsr       = 32'h44cf4f39;
    en_hist    = 3'b000;
    repeat (RESET_CYCLES) run_cycle(1'b0, 33'd0, 33'd0, 1'b0, 1'b0, 3'd0);
    rst_n = 1'b1;

    // rounding carries into the exponent
    run_cycle(1'b1, word_of(1'b0, 9'h0ff, 23'h7ffffe), word_of(1'b0, 9'h0ff, 23'h000001),
              1'b0, 1'b0, 3'd1);
    run_cycle(1'b1, word_of(1'b1, 9'h1f0, 23'd5), word_of(1'b0, 9'h180, 23'd0),
              1'b0, 1'b0, 3'd0);
    run_cycle(1'b1, word_of(1'b0, 9'h010, 23'd7), word_of(1'b1, 9'h020, 23'd3),
              1'b0, 1'b0, 3'd2);
    run_cycle(1'b1, word_of(1'b0, `FPM_EXP_INF, 23'd0), word_of(1'b1, 9'h000, 23'd0),
              1'b0, 1'b1, 3'd0);
    run_cycle(1'b1, word_of(1'b0, `FPM_EXP_NAN, 23'h123), word_of(1'b0, `FPM_EXP_INF, 23'd0),
              1'b1, 1'b1, 3'd5);

    for (i = 0; i < NUM_RANDOM; i++) begin
      rand_operand(op_a);
      rand_operand(op_b);
      // idle when [10:8] is zero, [7:5] rmode, [4] nan_signal, copy when [3:0] is zero
      take_bits(11, ctl);
      run_cycle(ctl[10:8] != 3'd0, op_a, op_b, ctl[3:0] == 4'd0, ctl[4], ctl[7:5]);
    end

    // drain the pipeline and watch out_en fall
    repeat (4) run_cycle(1'b0, 33'd0, 33'd0, 1'b0, 1'b0, 3'd0);
    assert (exp_q.size() == 0) else begin
      seq_errors++;
      $display("%0d expected results never came out", exp_q.size());
    end

    $display("errors: res %0d flags %0d sequence %0d", res_errors, flag_errors, seq_errors);
    if (res_errors + flag_errors + seq_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- source/fp_mul.sv
`timescale 1ns/1ps
`default_nettype none

module fp_mul import fp_mul_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        en,
  input  logic        copy_a,
  input  logic        nan_signal,
  input  logic [32:0] a,
  input  logic [32:0] b,
  input  round_mode_e rmode,
  output logic [32:0] res,
  output logic [3:0]  flags,
  output logic        out_en
);

  // exponent and special-case path
  logic signed [10:0] exp_sum;
  logic               sign;
  spec_class_e        spec;
  logic [32:0]        a_copy;
  logic               valid;

  // significand path
  logic [22:0]        frac_rnd;
  logic [1:0]         exp_inc;
  logic               inexact;

  fp_mul_mant mant_mod (
    .clk      (clk),
    .rst_n    (rst_n),
    .en       (en),
    .a_frac   (a[22:0]),
    .b_frac   (b[22:0]),
    .sign     (sign),
    .rmode    (rmode),
    .frac_rnd (frac_rnd),
    .exp_inc  (exp_inc),
    .inexact  (inexact)
  );

  fp_mul_exp exp_mod (
    .clk        (clk),
    .rst_n      (rst_n),
    .en         (en),
    .copy_a     (copy_a),
    .nan_signal (nan_signal),
    .a          (a),
    .b          (b),
    .exp_sum    (exp_sum),
    .sign       (sign),
    .spec       (spec),
    .a_copy     (a_copy),
    .valid      (valid)
  );

  fp_mul_pack pack_mod (
    .clk      (clk),
    .rst_n    (rst_n),
    .valid    (valid),
    .exp_sum  (exp_sum),
    .exp_inc  (exp_inc),
    .frac_rnd (frac_rnd),
    .inexact  (inexact),
    .sign     (sign),
    .spec     (spec),
    .a_copy   (a_copy),
    .res      (res),
    .flags    (flags),
    .out_en   (out_en)
  );

endmodule

`default_nettype wire

//--- source/fp_mul_pack.sv
`timescale 1ns/1ps
`default_nettype none

`include "fp_mul_cfg.svh"

module fp_mul_pack import fp_mul_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               valid,
  input  logic signed [10:0] exp_sum,
  input  logic [1:0]         exp_inc,
  input  logic [22:0]        frac_rnd,
  input  logic               inexact,
  input  logic               sign,
  input  spec_class_e        spec,
  input  logic [32:0]        a_copy,
  output logic [32:0]        res,
  output logic [3:0]         flags,
  output logic               out_en
);

  logic               sign_s2;
  logic signed [10:0] exp_fin;
  logic               ovf;
  logic               unf;
  logic [32:0]        res_d;
  logic [3:0]         flags_d;

  function automatic logic [32:0] fp_word(
    input logic        s,
    input logic [8:0]  e,
    input logic [22:0] f
  );
    fp_word = {e[8], s, e[7:0], f};
  endfunction

  // sign arrives a stage early and is realigned with the stage 2 data
  always_ff @(posedge clk) begin
    sign_s2 <= sign;
  end

  assign exp_fin = exp_sum + $signed({9'd0, exp_inc});
  assign ovf     = (exp_fin >= $signed({2'b00, `FPM_EXP_INF}));
  assign unf     = (exp_fin <= 11'sd0);

  always_comb begin
    res_d   = fp_word(sign_s2, exp_fin[8:0], frac_rnd);
    flags_d = 4'b0000;
    case (spec)
      SPEC_COPY: begin
        res_d = a_copy;
      end
      SPEC_SNAN: begin
        res_d = fp_word(1'b1, `FPM_EXP_NAN, `FPM_SNAN_FRAC);
        flags_d[`FPM_FLAG_INV] = 1'b1;
      end
      SPEC_QNAN: begin
        res_d = fp_word(1'b1, `FPM_EXP_NAN, `FPM_QNAN_FRAC);
      end
      SPEC_INF: begin
        res_d = fp_word(sign_s2, `FPM_EXP_INF, 23'd0);
      end
      SPEC_ZERO: begin
        res_d = fp_word(sign_s2, 9'h000, 23'd0);
      end
      default: begin
        // clamp to signed infinity or flush to signed zero
        if (ovf) begin
          res_d = fp_word(sign_s2, `FPM_EXP_INF, 23'd0);
          flags_d[`FPM_FLAG_OVF] = 1'b1;
          flags_d[`FPM_FLAG_INX] = 1'b1;
        end else if (unf) begin
          res_d = fp_word(sign_s2, 9'h000, 23'd0);
          flags_d[`FPM_FLAG_UNF] = 1'b1;
          flags_d[`FPM_FLAG_INX] = 1'b1;
        end else begin
          flags_d[`FPM_FLAG_INX] = inexact;
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_en <= 1'b0;
    end else begin
      out_en <= valid;
    end
  end

  // stage 3 outputs hold between results
  always_ff @(posedge clk) begin
    if (valid) begin
      res   <= res_d;
      flags <= flags_d;
    end
  end

  a_ovf_unf_excl: assert property (
    @(posedge clk) disable iff (!rst_n)
    valid |-> !(ovf && unf)
  ) else $error("fp_mul_pack: overflow and underflow flagged together");

endmodule

`default_nettype wire

//--- source/fp_mul_exp.sv
`timescale 1ns/1ps
`default_nettype none

`include "fp_mul_cfg.svh"

module fp_mul_exp import fp_mul_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               en,
  input  logic               copy_a,
  input  logic               nan_signal,
  input  logic [32:0]        a,
  input  logic [32:0]        b,
  output logic signed [10:0] exp_sum,
  output logic               sign,
  output spec_class_e        spec,
  output logic [32:0]        a_copy,
  output logic               valid
);

  logic [8:0]         exp_a;
  logic [8:0]         exp_b;
  logic               a_zero;
  logic               a_inf;
  logic               a_nan;
  logic               b_zero;
  logic               b_inf;
  logic               b_nan;
  logic signed [10:0] sum;
  spec_class_e        cls;

  logic signed [10:0] sum_s1;
  spec_class_e        cls_s1;
  logic [32:0]        a_s1;
  logic               valid_s1;

  // exponent high bit sits above the sign
  assign exp_a = {a[32], a[30:23]};
  assign exp_b = {b[32], b[30:23]};

  assign a_zero = (exp_a == 9'h000);
  assign a_inf  = (exp_a == `FPM_EXP_INF);
  assign a_nan  = (exp_a == `FPM_EXP_NAN);
  assign b_zero = (exp_b == 9'h000);
  assign b_inf  = (exp_b == `FPM_EXP_INF);
  assign b_nan  = (exp_b == `FPM_EXP_NAN);

  // signed so underflow shows up as zero or negative
  assign sum = $signed({2'b00, exp_a}) + $signed({2'b00, exp_b})
             - $signed({2'b00, `FPM_BIAS});

  always_comb begin
    if (copy_a) begin
      cls = SPEC_COPY;
    end else if (a_nan || b_nan || (a_inf && b_zero) || (a_zero && b_inf)) begin
      cls = nan_signal ? SPEC_SNAN : SPEC_QNAN;
    end else if (a_inf || b_inf) begin
      cls = SPEC_INF;
    end else if (a_zero || b_zero) begin
      cls = SPEC_ZERO;
    end else begin
      cls = SPEC_NONE;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_s1 <= 1'b0;
      valid    <= 1'b0;
    end else begin
      valid_s1 <= en;
      valid    <= valid_s1;
    end
  end

  // stage 1, sign leaves here for the rounding decision
  always_ff @(posedge clk) begin
    if (en) begin
      sum_s1 <= sum;
      sign   <= a[31] ^ b[31];
      cls_s1 <= cls;
      a_s1   <= a;
    end
  end

  // stage 2, lines up with the rounded fraction
  always_ff @(posedge clk) begin
    if (valid_s1) begin
      exp_sum <= sum_s1;
      spec    <= cls_s1;
      a_copy  <= a_s1;
    end
  end

  a_copy_class: assert property (
    @(posedge clk) disable iff (!rst_n)
    $past(en && copy_a, 2) |-> (spec == SPEC_COPY)
  ) else $error("fp_mul_exp: copy_a did not reach stage 2 as SPEC_COPY");

endmodule

`default_nettype wire

//--- source/fp_mul_mant.sv
`timescale 1ns/1ps
`default_nettype none

module fp_mul_mant import fp_mul_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        en,
  input  logic [22:0] a_frac,
  input  logic [22:0] b_frac,
  input  logic        sign,
  input  round_mode_e rmode,
  output logic [22:0] frac_rnd,
  output logic [1:0]  exp_inc,
  output logic        inexact
);

  logic [47:0] prod;
  logic [47:0] prod_s1;
  round_mode_e rmode_s1;
  logic        en_s1;

  logic [22:0] kept;
  logic        rnd_bit;
  logic        sticky;
  logic        norm_inc;
  logic        rnd_up;
  logic [23:0] kept_sum;

  // significands with the hidden one
  assign prod = {1'b1, a_frac} * {1'b1, b_frac};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      en_s1 <= 1'b0;
    end else begin
      en_s1 <= en;
    end
  end

  // stage 1
  always_ff @(posedge clk) begin
    if (en) begin
      prod_s1  <= prod;
      rmode_s1 <= rmode;
    end
  end

  // product lies in [1,4), top bit picks the shift
  always_comb begin
    if (prod_s1[47]) begin
      kept     = prod_s1[46:24];
      rnd_bit  = prod_s1[23];
      sticky   = |prod_s1[22:0];
      norm_inc = 1'b1;
    end else begin
      kept     = prod_s1[45:23];
      rnd_bit  = prod_s1[22];
      sticky   = |prod_s1[21:0];
      norm_inc = 1'b0;
    end
  end

  // sign is the stage 1 result sign from the exponent path
  always_comb begin
    case (rmode_s1)
      RND_NEAR: begin
        rnd_up = rnd_bit;
      end
      RND_EVEN: begin
        rnd_up = rnd_bit & (sticky | kept[0]);
      end
      RND_PLUS: begin
        rnd_up = rnd_bit & ~sign;
      end
      RND_MINUS: begin
        rnd_up = rnd_bit & sign;
      end
      RND_UP: begin
        rnd_up = (rnd_bit | sticky) & ~sign;
      end
      RND_DOWN: begin
        rnd_up = (rnd_bit | sticky) & sign;
      end
      default: begin
        rnd_up = 1'b0;
      end
    endcase
  end

  // carry out of all ones wraps the fraction to zero
  assign kept_sum = {1'b0, kept} + {23'd0, rnd_up};

  // stage 2
  always_ff @(posedge clk) begin
    if (en_s1) begin
      frac_rnd <= kept_sum[22:0];
      exp_inc  <= {1'b0, norm_inc} + {1'b0, kept_sum[23]};
      inexact  <= rnd_bit | sticky;
    end
  end

  a_rmode_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    en |-> !$isunknown(rmode)
  ) else $error("fp_mul_mant: rmode unknown while en is high");

endmodule

`default_nettype wire

//--- source/fp_mul_pkg.sv
`default_nettype none

package fp_mul_pkg;

  // code 7 is not named and rounds as truncate
  typedef enum logic [2:0] {
    RND_TRUNC = 3'd0,
    RND_NEAR  = 3'd1,
    RND_EVEN  = 3'd2,
    RND_PLUS  = 3'd3,
    RND_MINUS = 3'd4,
    RND_UP    = 3'd5,
    RND_DOWN  = 3'd6
  } round_mode_e;

  // special result classes, in order of precedence after none
  typedef enum logic [2:0] {
    SPEC_NONE = 3'd0,
    SPEC_COPY = 3'd1,
    SPEC_SNAN = 3'd2,
    SPEC_QNAN = 3'd3,
    SPEC_INF  = 3'd4,
    SPEC_ZERO = 3'd5
  } spec_class_e;

endpackage

`default_nettype wire

//--- source/fp_mul_cfg.svh
`ifndef FP_MUL_CFG_SVH
`define FP_MUL_CFG_SVH

// 33-bit register format, 9-bit biased exponent
`define FPM_BIAS      9'h0ff
`define FPM_EXP_INF   9'h1fe
`define FPM_EXP_NAN   9'h1ff

// nan fractions
`define FPM_QNAN_FRAC 23'h400001
`define FPM_SNAN_FRAC 23'h000001

// bit positions in the flags output
`define FPM_FLAG_INV  0
`define FPM_FLAG_OVF  1
`define FPM_FLAG_UNF  2
`define FPM_FLAG_INX  3

`endif
